// ==== wave_reader.f ====
rtl/wave_pkg.sv
rtl/phase_accumulator.sv
rtl/quarter_sine_rom.sv
rtl/voice_sequencer.sv
rtl/sample_bank.sv
rtl/midi_wave_reader.sv
tests/wave_reader_properties.sv
tests/wave_reader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert \
    --top-module wave_reader_tb \
    -f wave_reader.f \
    -o wave_reader_sim &&
./obj_dir/wave_reader_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "test passed" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

// ==== tests/wave_reader_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module wave_reader_tb;

    import wave_pkg::*;

    localparam int NUM_VOICES = DEFAULT_NUM_VOICES;
    localparam int ROM_WAIT = DEFAULT_ROM_WAIT;
    localparam int PERIOD = 20;
    localparam int LATENCY = 1 + NUM_VOICES * (ROM_WAIT + 1);
    localparam int BUSY_PULSE_CYCLE = LATENCY / 2;

    localparam int NUM_RANDOM = 48;
    localparam int NUM_REQUESTS = NUM_RANDOM + 2 + 1;
    localparam int MARGIN = 16;
    localparam int WATCHDOG_NS = NUM_REQUESTS * (LATENCY + MARGIN) * PERIOD;

    localparam logic [31:0] LFSR_SEED = 32'h4445_20a7;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clk;
    logic reset;
    logic generate_next;
    logic zero;
    phase_step_t [NUM_VOICES-1:0] steps;
    logic samples_ready;
    sample_t [NUM_VOICES-1:0] samples;

    logic [31:0] lfsr_state;

    // shadow phases
    phase_pos_t model_pos [NUM_VOICES];
    quadrant_t model_quad [NUM_VOICES];
    logic [3:0] quadrants_seen;

    midi_wave_reader #(
        .NUM_VOICES (NUM_VOICES),
        .ROM_WAIT   (ROM_WAIT)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .generate_next (generate_next),
        .zero          (zero),
        .steps         (steps),
        .samples_ready (samples_ready),
        .samples       (samples)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $fatal(1, "timeout");
    end

    // bound sequencer assertions count their failures
    always @(negedge clk) begin
        if (DUT.u_seq.u_props.failures != 0) begin
            $display("a bound assertion on the sequencer fired");
            $display("test failed");
            $fatal(1, "assertion failure");
        end
    end

    ////////////////////////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // width 0..20, or full 20 bits to force reflections
    task automatic randomize_steps(input logic force_large);
        logic [31:0] width_bits;
        logic [31:0] value;
        int width;
        int v;
        for (v = 0; v < NUM_VOICES; v++) begin
            if (force_large) begin
                width = 20;
            end else begin
                take_bits(5, width_bits);
                width = int'(width_bits) % 21;
            end
            take_bits(width, value);
            steps[v] = phase_step_t'(value);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    task automatic clear_model();
        int v;
        for (v = 0; v < NUM_VOICES; v++) begin
            model_pos[v] = '0;
            model_quad[v] = '0;
        end
    endtask

    task automatic advance_model();
        int p;
        int s;
        int v;
        for (v = 0; v < NUM_VOICES; v++) begin
            p = int'(model_pos[v]);
            s = int'(steps[v]);
            if (!model_quad[v][0]) begin
                // climbing, reflect at the peak
                if (p + s >= int'(POS_MAX)) begin
                    model_pos[v] = phase_pos_t'(int'(POS_MAX)
                        - ((p + s + int'(REFLECT_OFFSET)) % 1048576));
                    model_quad[v] = model_quad[v] + 2'd1;
                end else begin
                    model_pos[v] = phase_pos_t'(p + s);
                end
            end else begin
                // falling, reflect at zero
                if (s >= p) begin
                    model_pos[v] = phase_pos_t'((s - p + int'(REFLECT_OFFSET)) % 1048576);
                    model_quad[v] = model_quad[v] + 2'd1;
                end else begin
                    model_pos[v] = phase_pos_t'(p - s);
                end
            end
            quadrants_seen[model_quad[v]] = 1'b1;
        end
    endtask

    function automatic sample_t predict_sample(input int v);
        sample_t mag;
        mag = quarter_sine_value(model_pos[v][19:10]);
        if (model_quad[v][1]) begin
            return sample_t'(-mag);
        end
        return mag;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_sample(input sample_t actual, input sample_t expected,
                                input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s got %0d expected %0d",
                     $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_ready(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s got %b expected %b",
                     $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "samples_ready mismatch");
        end
    endtask

    task automatic check_all_samples(input logic expect_zero);
        int v;
        for (v = 0; v < NUM_VOICES; v++) begin
            if (expect_zero) begin
                check_sample(samples[v], sample_t'(0), $sformatf("voice %0d cleared", v));
            end else begin
                check_sample(samples[v], predict_sample(v), $sformatf("voice %0d sample", v));
            end
        end
    endtask

    // called at a falling edge with steps already driven
    task automatic run_request(input logic busy_pulse);
        int cycle;
        generate_next = 1'b1;
        advance_model();
        for (cycle = 1; cycle <= LATENCY; cycle++) begin
            @(negedge clk);
            generate_next = busy_pulse && (cycle == BUSY_PULSE_CYCLE);
            check_ready(samples_ready, cycle == LATENCY, "samples_ready timing");
        end
        check_all_samples(1'b0);
        @(negedge clk);
        check_ready(samples_ready, 1'b0, "samples_ready after pulse");
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] gap;
        int n;
        reset = 1'b1;
        generate_next = 1'b0;
        zero = 1'b0;
        steps = '0;
        lfsr_state = LFSR_SEED;
        quadrants_seen = 4'b0001;
        clear_model();

        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_ready(samples_ready, 1'b0, "samples_ready after reset");
        check_all_samples(1'b1);

        // random steps, every fourth one full width
        for (n = 0; n < NUM_RANDOM; n++) begin
            randomize_steps(n % 4 == 3);
            run_request(1'b0);
            take_bits(2, gap);
            repeat (int'(gap)) @(negedge clk);
        end

        // requests while busy are dropped
        randomize_steps(1'b0);
        run_request(1'b1);
        randomize_steps(1'b1);
        run_request(1'b1);

        // clear while idle
        zero = 1'b1;
        @(negedge clk);
        zero = 1'b0;
        clear_model();
        check_ready(samples_ready, 1'b0, "samples_ready after zero");
        check_all_samples(1'b1);
        randomize_steps(1'b0);
        run_request(1'b0);

        if (quadrants_seen != 4'b1111) begin
            $display("the random steps never reached all four quadrants");
            $display("test failed");
            $fatal(1, "quadrant coverage");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/wave_reader_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module wave_reader_properties (
    input wire                       clk,
    input wire                       reset,
    input wire wave_pkg::seq_state_t state,
    input wire                       accept,
    input wire                       load,
    input wire                       samples_ready
);

    import wave_pkg::*;

    // read by the testbench monitor
    int unsigned failures = 0;

    ready_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        samples_ready |=> !samples_ready
    ) else begin
        failures++;
        $error("samples_ready high for two cycles");
    end

    // an accepted request opens a read frame
    accept_starts_read: assert property (
        @(posedge clk) disable iff (reset)
        accept |=> (state == SEQ_READ)
    ) else begin
        failures++;
        $error("accept did not start a read frame");
    end

    // ROM address held at least a cycle before load
    load_after_read: assert property (
        @(posedge clk) disable iff (reset)
        load |-> $past(state == SEQ_READ)
    ) else begin
        failures++;
        $error("load without a preceding read cycle");
    end

endmodule

bind voice_sequencer wave_reader_properties u_props (
    .clk           (clk),
    .reset         (reset),
    .state         (state),
    .accept        (accept),
    .load          (load),
    .samples_ready (samples_ready)
);

`default_nettype wire

// ==== rtl/midi_wave_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module midi_wave_reader #(
    parameter int NUM_VOICES = wave_pkg::DEFAULT_NUM_VOICES,
    parameter int ROM_WAIT = wave_pkg::DEFAULT_ROM_WAIT
) (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire                                    generate_next,
    input  wire                                    zero,
    input  wire wave_pkg::phase_step_t [NUM_VOICES-1:0] steps,
    output logic                                   samples_ready,
    output wave_pkg::sample_t [NUM_VOICES-1:0]     samples
);

    import wave_pkg::*;

    localparam int IDX_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1;

    phase_pos_t [NUM_VOICES-1:0] pos;
    quadrant_t [NUM_VOICES-1:0] quadrant;
    rom_addr_t rom_addr;
    sample_t rom_data;
    logic [IDX_W-1:0] voice_index;
    logic accept;
    logic load;
    logic negate;

    // one phase register per voice, all step on accept
    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        phase_accumulator u_phase (
            .clk      (clk),
            .reset    (reset),
            .zero     (zero),
            .accept   (accept),
            .step     (steps[v]),
            .pos      (pos[v]),
            .quadrant (quadrant[v])
        );
    end

    quarter_sine_rom u_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    voice_sequencer #(
        .NUM_VOICES (NUM_VOICES),
        .ROM_WAIT   (ROM_WAIT)
    ) u_seq (
        .clk           (clk),
        .reset         (reset),
        .generate_next (generate_next),
        .pos           (pos),
        .quadrant      (quadrant),
        .accept        (accept),
        .rom_addr      (rom_addr),
        .voice_index   (voice_index),
        .load          (load),
        .negate        (negate),
        .samples_ready (samples_ready)
    );

    sample_bank #(
        .NUM_VOICES (NUM_VOICES)
    ) u_bank (
        .clk         (clk),
        .reset       (reset),
        .zero        (zero),
        .load        (load),
        .negate      (negate),
        .voice_index (voice_index),
        .rom_data    (rom_data),
        .samples     (samples)
    );

endmodule

`default_nettype wire

// ==== rtl/sample_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_bank #(
    parameter int NUM_VOICES = wave_pkg::DEFAULT_NUM_VOICES,
    localparam int IDX_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                zero,
    input  wire                                load,
    input  wire                                negate,
    input  wire [IDX_W-1:0]                    voice_index,
    input  wire wave_pkg::sample_t             rom_data,
    output wave_pkg::sample_t [NUM_VOICES-1:0] samples
);

    import wave_pkg::*;

    sample_t load_value;

    // negative half-wave
    assign load_value = negate ? -rom_data : rom_data;

    ////////////////////////////////////////////////////////////
    // sample registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || zero) begin
            samples <= '0;
        end else if (load) begin
            samples[voice_index] <= load_value;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/voice_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module voice_sequencer #(
    parameter int NUM_VOICES = wave_pkg::DEFAULT_NUM_VOICES,
    parameter int ROM_WAIT = wave_pkg::DEFAULT_ROM_WAIT,
    localparam int IDX_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1
) (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   generate_next,
    input  wire wave_pkg::phase_pos_t [NUM_VOICES-1:0] pos,
    input  wire wave_pkg::quadrant_t [NUM_VOICES-1:0]  quadrant,
    output logic                                  accept,
    output wave_pkg::rom_addr_t                   rom_addr,
    output logic [IDX_W-1:0]                      voice_index,
    output logic                                  load,
    output logic                                  negate,
    output logic                                  samples_ready
);

    import wave_pkg::*;

    // ROM_WAIT must be at least 1 so the registered ROM data is ready by load
    localparam int WAIT_W = (ROM_WAIT > 0) ? $clog2(ROM_WAIT + 1) : 1;
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(ROM_WAIT);
    localparam logic [IDX_W-1:0] VOICE_LAST = IDX_W'(NUM_VOICES - 1);

    seq_state_t state;
    logic [WAIT_W-1:0] wait_cnt;
    logic last_voice;

    assign accept = (state == SEQ_IDLE) && generate_next;
    assign last_voice = (voice_index == VOICE_LAST);

    // current voice drives the shared ROM
    assign rom_addr = pos[voice_index][19:10];
    assign negate = quadrant[voice_index][1];
    assign load = (state == SEQ_READ) && (wait_cnt == WAIT_LAST);

    ////////////////////////////////////////////////////////////
    // slot walk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_IDLE;
            voice_index <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    voice_index <= '0;
                    wait_cnt <= '0;
                    if (accept) begin
                        state <= SEQ_READ;
                    end
                end
                SEQ_READ: begin
                    if (wait_cnt == WAIT_LAST) begin
                        wait_cnt <= '0;
                        if (last_voice) begin
                            state <= SEQ_IDLE;
                            voice_index <= '0;
                        end else begin
                            voice_index <= voice_index + 1'b1;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // high in the cycle the last sample lands
    always_ff @(posedge clk) begin
        if (reset) begin
            samples_ready <= 1'b0;
        end else begin
            samples_ready <= load && last_voice;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/quarter_sine_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module quarter_sine_rom (
    input  wire                    clk,
    input  wire wave_pkg::rom_addr_t addr,
    output wave_pkg::sample_t      data
);

    import wave_pkg::*;

    localparam int ROM_DEPTH = 2 ** $bits(rom_addr_t);

    sample_t table_mem [0:ROM_DEPTH-1];

    // table built from the shared function at elaboration
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            table_mem[i] = quarter_sine_value(rom_addr_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        data <= table_mem[addr];
    end

endmodule

`default_nettype wire

// ==== rtl/phase_accumulator.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_accumulator (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      zero,
    input  wire                      accept,
    input  wire wave_pkg::phase_step_t step,
    output wave_pkg::phase_pos_t     pos,
    output wave_pkg::quadrant_t      quadrant
);

    import wave_pkg::*;

    phase_pos_t up_sum;
    phase_pos_t up_pos;
    phase_pos_t down_pos;
    phase_pos_t next_pos;
    quadrant_t next_quadrant;
    logic up_reflect;
    logic down_reflect;

    ////////////////////////////////////////////////////////////
    // next phase
    ////////////////////////////////////////////////////////////

    always_comb begin
        // even quadrants climb toward the peak
        up_sum = pos + step + REFLECT_OFFSET;
        up_reflect = (pos >= POS_MAX - step);
        up_pos = up_reflect ? POS_MAX - up_sum : pos + step;

        // odd quadrants walk back toward zero
        down_reflect = (step >= pos);
        down_pos = down_reflect ? step + REFLECT_OFFSET - pos : pos - step;

        if (quadrant[0]) begin
            next_pos = down_pos;
            next_quadrant = down_reflect ? quadrant + 2'd1 : quadrant;
        end else begin
            next_pos = up_pos;
            next_quadrant = up_reflect ? quadrant + 2'd1 : quadrant;
        end
    end

    ////////////////////////////////////////////////////////////
    // phase register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || zero) begin
            pos <= '0;
            quadrant <= '0;
        end else if (accept) begin
            pos <= next_pos;
            // 3 wraps back to 0
            quadrant <= next_quadrant;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/wave_pkg.sv ====
`default_nettype none

package wave_pkg;

    typedef logic [19:0] phase_pos_t;
    typedef logic [1:0] quadrant_t;
    typedef logic [19:0] phase_step_t;
    typedef logic [9:0] rom_addr_t;
    typedef logic signed [15:0] sample_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_READ
    } seq_state_t;

    localparam int DEFAULT_NUM_VOICES = 8;
    localparam int DEFAULT_ROM_WAIT = 3;

    localparam phase_pos_t POS_MAX = 20'hfffff;
    localparam phase_pos_t REFLECT_OFFSET = 20'd1024;

    // sin(pi/2 * x) ~ c1 x - c3 x^3 + c5 x^5, coefficients scaled by 32767
    localparam int SINE_C1 = 51471;
    localparam int SINE_C3 = 21166;
    localparam int SINE_C5 = 2611;
    localparam int SINE_PEAK = 32767;

    function automatic sample_t quarter_sine_value(rom_addr_t addr);
        int x;
        int x2;
        int x3;
        int x5;
        int acc;
        // x in units of 1/1024 of the quarter wave
        x = int'(addr);
        x2 = (x * x) / 1024;
        x3 = (x2 * x) / 1024;
        x5 = (x3 * x2) / 1024;
        acc = (SINE_C1 * x - SINE_C3 * x3 + SINE_C5 * x5) / 1024;
        // polynomial overshoots slightly near the peak
        if (acc > SINE_PEAK) begin
            acc = SINE_PEAK;
        end
        return sample_t'(acc);
    endfunction

endpackage

`default_nettype wire
